//--- Makefile
# Verilator flow for the reorder buffer
VERILATOR  ?= verilator
TOP        := rob_tb
FILELIST   := rob.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the run prints the pass message
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- rob.f
rob_pkg.sv
rob_pointers.sv
rob_entry_array.sv
rob_retire_select.sv
rob_top.sv
rob_tb.sv

//--- rob_entry_array.sv
//--------------------------------------------------------------------------
// Entry storage. A completion for an invalid entry is dropped
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    input  logic                                              flush_i,
    input  rob_pkg::rob_idx_t                                 tail_i,
    input  rob_pkg::dp_rob_t                                  dp_rob_i,
    input  rob_pkg::cdb_t       [rob_pkg::CDB_NUM-1:0]        cdb_i,
    input  logic                [rob_pkg::ROB_ENTRY_NUM-1:0]  rt_sel_i,
    output rob_pkg::rob_entry_t [rob_pkg::ROB_ENTRY_NUM-1:0]  entries_o
);
    import rob_pkg::*;

    // Control state
    logic     [ROB_ENTRY_NUM-1:0] valid_q;
    logic     [ROB_ENTRY_NUM-1:0] complete_q;

    // Payload
    dp_slot_t [ROB_ENTRY_NUM-1:0] slot_q;
    logic     [ROB_ENTRY_NUM-1:0] br_result_q;
    addr_t    [ROB_ENTRY_NUM-1:0] br_target_q;

    // Dispatch decode, per entry
    logic     [ROB_ENTRY_NUM-1:0] dp_sel;
    dp_slot_t [ROB_ENTRY_NUM-1:0] dp_data;

    // Completion decode, per entry
    logic     [ROB_ENTRY_NUM-1:0] cp_sel;
    cdb_t     [ROB_ENTRY_NUM-1:0] cp_data;
    logic     [ROB_ENTRY_NUM-1:0] cp_en;

//--------------------------------------------------------------------------
// Dispatch select
//--------------------------------------------------------------------------
    always_comb begin
        dp_sel  = '0;
        dp_data = '0;
        // Slot k lands at tail+k, wrapping
        for (int k = 0; k < DP_NUM; k++) begin
            if (k < int'(dp_rob_i.dp_num)) begin
                dp_sel[rob_idx_add(tail_i, k)]  = 1'b1;
                dp_data[rob_idx_add(tail_i, k)] = dp_rob_i.slot[k];
            end
        end
    end

//--------------------------------------------------------------------------
// Completion match
//--------------------------------------------------------------------------
    always_comb begin
        cp_sel  = '0;
        cp_data = '0;
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            // Higher channel wins on a duplicate index
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].rob_idx == rob_idx_t'(e))) begin
                    cp_sel[e]  = 1'b1;
                    cp_data[e] = cdb_i[c];
                end
            end
        end
    end

    // Completion loses to dispatch and retire on the same entry
    assign cp_en = cp_sel & valid_q & ~dp_sel & ~rt_sel_i;

//--------------------------------------------------------------------------
// Entry update
//--------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // Reset and flush both empty the ROB
            valid_q    <= '0;
            complete_q <= '0;
        end else begin
            for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
                if (dp_sel[e]) begin
                    valid_q[e]    <= 1'b1;
                    complete_q[e] <= 1'b0;
                end else if (rt_sel_i[e]) begin
                    valid_q[e]    <= 1'b0;
                    complete_q[e] <= 1'b0;
                end else if (cp_en[e]) begin
                    complete_q[e] <= 1'b1;
                end
            end
        end
    end

    // Payload is only read behind valid and complete
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            if (dp_sel[e]) begin
                slot_q[e] <= dp_data[e];
            end
            if (cp_en[e]) begin
                br_result_q[e] <= cp_data[e].br_result;
                br_target_q[e] <= cp_data[e].br_target;
            end
        end
    end

//--------------------------------------------------------------------------
// Entry view
//--------------------------------------------------------------------------
    always_comb begin
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            entries_o[e].valid      = valid_q[e];
            entries_o[e].complete   = complete_q[e];
            entries_o[e].pc         = slot_q[e].pc;
            entries_o[e].rd         = slot_q[e].rd;
            entries_o[e].tag        = slot_q[e].tag;
            entries_o[e].tag_old    = slot_q[e].tag_old;
            entries_o[e].br_predict = slot_q[e].br_predict;
            entries_o[e].br_result  = br_result_q[e];
            entries_o[e].br_target  = br_target_q[e];
        end
    end

endmodule

`default_nettype wire

//--- rob_pkg.sv
//--------------------------------------------------------------------------
// Sizing for a 16-entry ROB. DP_NUM and RT_NUM must not exceed ROB_ENTRY_NUM
//--------------------------------------------------------------------------
`default_nettype none

package rob_pkg;

//--------------------------------------------------------------------------
// Sizing
//--------------------------------------------------------------------------
    localparam int ROB_ENTRY_NUM = 16;
    localparam int DP_NUM        = 2;
    localparam int CDB_NUM       = 2;
    localparam int RT_NUM        = 2;
    localparam int ARCH_REG_NUM  = 32;
    localparam int PHY_REG_NUM   = 64;
    localparam int XLEN          = 32;

    // Derived index widths
    localparam int ROB_IDX_W = $clog2(ROB_ENTRY_NUM);
    localparam int TAG_W     = $clog2(PHY_REG_NUM);
    localparam int ARCH_W    = $clog2(ARCH_REG_NUM);

    // Count widths, 0 up to the full width inclusive
    localparam int DP_CNT_W = $clog2(DP_NUM + 1);
    localparam int RT_CNT_W = $clog2(RT_NUM + 1);

//--------------------------------------------------------------------------
// Scalar types
//--------------------------------------------------------------------------
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [ARCH_W-1:0]    arch_reg_t;
    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [DP_CNT_W-1:0]  dp_cnt_t;
    typedef logic [RT_CNT_W-1:0]  rt_cnt_t;

//--------------------------------------------------------------------------
// Bundles
//--------------------------------------------------------------------------
    // One instruction from the dispatcher
    typedef struct packed {
        addr_t     pc;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
        logic      br_predict;
    } dp_slot_t;

    // Dispatch group, slot 0 is the oldest
    typedef struct packed {
        dp_cnt_t               dp_num;
        dp_slot_t [DP_NUM-1:0] slot;
    } dp_rob_t;

    // Free slots and the indices the next group will get
    typedef struct packed {
        dp_cnt_t               avail_num;
        rob_idx_t [DP_NUM-1:0] rob_idx;
    } rob_dp_t;

    // One result-bus channel
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     br_result;
        addr_t    br_target;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        logic      complete;
        addr_t     pc;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
        logic      br_predict;
        logic      br_result;
        addr_t     br_target;
    } rob_entry_t;

    // Retire record for map table and free list
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
    } rob_rt_t;

    // Modulo add on entry indices, offset below ROB_ENTRY_NUM
    function automatic rob_idx_t rob_idx_add(rob_idx_t base, int unsigned offset);
        int unsigned sum;
        sum = 32'(base) + offset;
        if (sum >= ROB_ENTRY_NUM) begin
            sum = sum - ROB_ENTRY_NUM;
        end
        return rob_idx_t'(sum);
    endfunction

endpackage

`default_nettype wire

//--- rob_pointers.sv
//--------------------------------------------------------------------------
// Head and tail with lap flags. The dispatcher must keep dp_num <= avail_num
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rob_pointers (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              flush_i,
    input  rob_pkg::dp_cnt_t  dp_num_i,
    input  rob_pkg::rt_cnt_t  rt_num_i,
    output rob_pkg::rob_idx_t head_o,
    output rob_pkg::rob_idx_t tail_o,
    output rob_pkg::rob_dp_t  rob_dp_o
);
    import rob_pkg::*;

    rob_idx_t head_q;
    rob_idx_t tail_q;
    // Lap flags, equal pointers with differing flags mean full
    logic     head_wrap_q;
    logic     tail_wrap_q;

    // One extra bit to catch the wrap
    logic [ROB_IDX_W:0]   head_sum;
    logic [ROB_IDX_W:0]   tail_sum;
    logic [ROB_IDX_W:0]   free_cnt;
    logic [ROB_IDX_W+1:0] open_cnt;

//--------------------------------------------------------------------------
// Pointer advance
//--------------------------------------------------------------------------
    assign head_sum = {1'b0, head_q} + (ROB_IDX_W+1)'(rt_num_i);
    assign tail_sum = {1'b0, tail_q} + (ROB_IDX_W+1)'(dp_num_i);

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // Flush restarts the ROB at entry 0
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else begin
            head_q <= rob_idx_add(head_q, rt_num_i);
            tail_q <= rob_idx_add(tail_q, dp_num_i);
            // Toggle lap flag when passing the last entry
            if (head_sum >= ROB_ENTRY_NUM) begin
                head_wrap_q <= ~head_wrap_q;
            end
            if (tail_sum >= ROB_ENTRY_NUM) begin
                tail_wrap_q <= ~tail_wrap_q;
            end
        end
    end

//--------------------------------------------------------------------------
// Free count and upcoming indices
//--------------------------------------------------------------------------
    always_comb begin
        if (head_wrap_q == tail_wrap_q) begin
            // Same lap so tail is at or ahead of head
            free_cnt = (ROB_IDX_W+1)'(ROB_ENTRY_NUM) - ({1'b0, tail_q} - {1'b0, head_q});
        end else begin
            // Tail has lapped head
            free_cnt = {1'b0, head_q} - {1'b0, tail_q};
        end

        // Entries retiring this cycle are free at the edge too
        open_cnt = {1'b0, free_cnt} + (ROB_IDX_W+2)'(rt_num_i);

        // Saturate at the dispatch width
        if (open_cnt >= (ROB_IDX_W+2)'(DP_NUM)) begin
            rob_dp_o.avail_num = dp_cnt_t'(DP_NUM);
        end else begin
            rob_dp_o.avail_num = dp_cnt_t'(open_cnt);
        end

        for (int i = 0; i < DP_NUM; i++) begin
            rob_dp_o.rob_idx[i] = rob_idx_add(tail_q, i);
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

`default_nettype wire

//--- rob_retire_select.sv
//--------------------------------------------------------------------------
// Combinational retire. An exception suppresses the whole group
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rob_retire_select (
    input  rob_pkg::rob_idx_t                                head_i,
    input  rob_pkg::rob_entry_t [rob_pkg::ROB_ENTRY_NUM-1:0] entries_i,
    input  logic                                             exception_i,
    output logic                [rob_pkg::ROB_ENTRY_NUM-1:0] rt_sel_o,
    output rob_pkg::rt_cnt_t                                 rt_num_o,
    output rob_pkg::rob_rt_t    [rob_pkg::RT_NUM-1:0]        rob_rt_o,
    output logic                                             br_mis_valid_o,
    output rob_pkg::addr_t                                   br_target_o,
    output logic                                             flush_o
);
    import rob_pkg::*;

    // Retire window, position 0 is the head
    rob_idx_t   [RT_NUM-1:0] win_idx;
    rob_entry_t [RT_NUM-1:0] win_ent;

    logic       [RT_NUM-1:0] rt_valid;
    logic       [RT_NUM-1:0] mis;

//--------------------------------------------------------------------------
// Window gather
//--------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < RT_NUM; i++) begin
            win_idx[i] = rob_idx_add(head_i, i);
            win_ent[i] = entries_i[win_idx[i]];
        end
    end

//--------------------------------------------------------------------------
// Ready chain
//--------------------------------------------------------------------------
    always_comb begin : ready_chain
        logic chain;

        // Nothing retires while an exception flushes
        chain          = ~exception_i;
        br_mis_valid_o = 1'b0;
        br_target_o    = '0;

        for (int i = 0; i < RT_NUM; i++) begin
            rt_valid[i] = chain && win_ent[i].valid && win_ent[i].complete;
            mis[i]      = rt_valid[i] && (win_ent[i].br_result != win_ent[i].br_predict);
            // At most one hit, the chain stops right after it
            if (mis[i]) begin
                br_mis_valid_o = 1'b1;
                br_target_o    = win_ent[i].br_target;
            end
            // Mispredicted branch retires, younger ones do not
            chain = rt_valid[i] && !mis[i];
        end
    end

//--------------------------------------------------------------------------
// Selects, count and records
//--------------------------------------------------------------------------
    always_comb begin
        rt_sel_o = '0;
        rt_num_o = '0;
        for (int i = 0; i < RT_NUM; i++) begin
            if (rt_valid[i]) begin
                rt_sel_o[win_idx[i]] = 1'b1;
                rt_num_o             = rt_num_o + rt_cnt_t'(1);
            end
            rob_rt_o[i].valid   = rt_valid[i];
            rob_rt_o[i].pc      = win_ent[i].pc;
            rob_rt_o[i].rd      = win_ent[i].rd;
            rob_rt_o[i].tag     = win_ent[i].tag;
            rob_rt_o[i].tag_old = win_ent[i].tag_old;
        end
    end

    // Flush for pointers and entries, taken at the next edge
    assign flush_o = exception_i | br_mis_valid_o;

endmodule

`default_nettype wire

//--- rob_tb.sv
//--------------------------------------------------------------------------
// ROB testbench. Stimulus keeps dp_num within avail_num, one CDB hit per entry
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
    import rob_pkg::*;

    // Model entry in program order
    typedef struct packed {
        rob_idx_t idx;
        dp_slot_t slot;
        logic     complete;
        logic     br_result;
        addr_t    br_target;
    } model_ent_t;

    // Expected DUT outputs for one cycle
    typedef struct packed {
        rob_rt_t [RT_NUM-1:0] rt;
        rt_cnt_t              rt_num;
        logic                 mis;
        addr_t                target;
        rob_dp_t              dp;
    } expect_t;

    logic                 clk_i     = 1'b0;
    logic                 rst_i     = 1'b1;
    dp_rob_t              dp_rob    = '0;
    cdb_t [CDB_NUM-1:0]   cdb       = '0;
    logic                 exception = 1'b0;
    rob_dp_t              rob_dp;
    rob_rt_t [RT_NUM-1:0] rob_rt;
    logic                 br_mis_valid;
    addr_t                br_target;

    // Model state, valid between edges
    model_ent_t  model_q[$];
    rob_idx_t    model_tail = '0;
    logic [31:0] lfsr_q     = 32'h1ff7_2e16;
    string       test_name  = "reset";
    int          disp_cnt   = 0;
    // Retire records seen valid at the DUT outputs
    int          ret_cnt    = 0;

    rob_top dut0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dp_rob_i       (dp_rob),
        .rob_dp_o       (rob_dp),
        .cdb_i          (cdb),
        .exception_i    (exception),
        .rob_rt_o       (rob_rt),
        .br_mis_valid_o (br_mis_valid),
        .br_target_o    (br_target)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

//--------------------------------------------------------------------------
// Random source and reference model
//--------------------------------------------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic expect_t predict_outputs(logic exc);
        expect_t e;
        logic    go;
        int      open;
        e  = '0;
        go = !exc;
        for (int i = 0; i < RT_NUM; i++) begin
            // Oldest first, stop at a gap
            go = go && (i < model_q.size()) && model_q[i].complete;
            if (go) begin
                e.rt[i]  = {1'b1, model_q[i].slot.pc, model_q[i].slot.rd,
                            model_q[i].slot.tag, model_q[i].slot.tag_old};
                e.rt_num = e.rt_num + 1'b1;
                // Mispredicted branch is the last one in the group
                if (model_q[i].br_result != model_q[i].slot.br_predict) begin
                    e.mis    = 1'b1;
                    e.target = model_q[i].br_target;
                    go       = 1'b0;
                end
            end
        end
        // Free entries before the edge plus this cycle's retires, capped
        open           = ROB_ENTRY_NUM - model_q.size() + int'(e.rt_num);
        e.dp.avail_num = dp_cnt_t'((open < DP_NUM) ? open : DP_NUM);
        for (int i = 0; i < DP_NUM; i++) begin
            e.dp.rob_idx[i] = rob_idx_t'((int'(model_tail) + i) % ROB_ENTRY_NUM);
        end
        return e;
    endfunction

    // Moves the model across one edge
    function automatic void update_model(expect_t e);
        model_ent_t m;
        if (exception || e.mis) begin
            // Flush drops everything, dispatch included
            model_q.delete();
            model_tail = '0;
        end else begin
            repeat (int'(e.rt_num)) begin
                void'(model_q.pop_front());
            end
            foreach (model_q[j]) begin
                for (int c = 0; c < CDB_NUM; c++) begin
                    if (cdb[c].valid && cdb[c].rob_idx == model_q[j].idx) begin
                        m           = model_q[j];
                        m.complete  = 1'b1;
                        m.br_result = cdb[c].br_result;
                        m.br_target = cdb[c].br_target;
                        model_q[j]  = m;
                    end
                end
            end
            for (int k = 0; k < int'(dp_rob.dp_num); k++) begin
                m      = '0;
                m.idx  = model_tail;
                m.slot = dp_rob.slot[k];
                model_q.push_back(m);
                model_tail = rob_idx_t'((int'(model_tail) + 1) % ROB_ENTRY_NUM);
                disp_cnt++;
            end
        end
    endfunction

//--------------------------------------------------------------------------
// Checking
//--------------------------------------------------------------------------
    task automatic compare_value(string what, logic [63:0] exp_val, logic [63:0] act_val);
        if (exp_val !== act_val) begin
            $display("mismatch %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("** FAIL **");
        $fatal(1, "stopped on timeout");
    endtask

    // Inputs settled since 1 ns after the edge, outputs stable here
    always @(negedge clk_i) begin : compare_outputs
        expect_t e;
        if (!rst_i) begin
            e = predict_outputs(exception);
            compare_value("avail_num", e.dp.avail_num, rob_dp.avail_num);
            compare_value("rob_idx", e.dp.rob_idx, rob_dp.rob_idx);
            for (int i = 0; i < RT_NUM; i++) begin
                compare_value($sformatf("retire %0d valid", i), e.rt[i].valid, rob_rt[i].valid);
                if (e.rt[i].valid) begin
                    compare_value($sformatf("retire %0d record", i), e.rt[i], rob_rt[i]);
                end
                if (rob_rt[i].valid) begin
                    ret_cnt++;
                end
            end
            compare_value("br_mis_valid", e.mis, br_mis_valid);
            if (e.mis) begin
                compare_value("br_target", e.target, br_target);
            end
            update_model(e);
        end
    end

//--------------------------------------------------------------------------
// Stimulus
//--------------------------------------------------------------------------
    // To 1 ns after the next edge, inputs back to idle
    task automatic tick();
        @(posedge clk_i);
        #1;
        dp_rob    = '0;
        cdb       = '0;
        exception = 1'b0;
    endtask

    task automatic set_dispatch(int n);
        expect_t e;
        e             = predict_outputs(exception);
        dp_rob.dp_num = dp_cnt_t'((n < int'(e.dp.avail_num)) ? n : int'(e.dp.avail_num));
        for (int k = 0; k < DP_NUM; k++) begin
            dp_rob.slot[k].pc         = addr_t'(rand_bits(XLEN));
            dp_rob.slot[k].rd         = arch_reg_t'(rand_bits(ARCH_W));
            dp_rob.slot[k].tag        = tag_t'(rand_bits(TAG_W));
            dp_rob.slot[k].tag_old    = tag_t'(rand_bits(TAG_W));
            dp_rob.slot[k].br_predict = rand_bits(1) != 0;
        end
    endtask

    // Channel ch completes the entry at model position pos
    task automatic set_completion(int ch, int pos, logic mispredict);
        cdb[ch].valid     = 1'b1;
        cdb[ch].rob_idx   = model_q[pos].idx;
        cdb[ch].br_result = model_q[pos].slot.br_predict ^ mispredict;
        cdb[ch].br_target = addr_t'(rand_bits(XLEN));
    endtask

    task automatic complete_random();
        int   pos;
        logic dup;
        for (int c = 0; c < CDB_NUM; c++) begin
            if (model_q.size() != 0) begin
                pos = int'(rand_bits(4)) % model_q.size();
                dup = 1'b0;
                for (int d = 0; d < c; d++) begin
                    dup = dup | (cdb[d].valid && cdb[d].rob_idx == model_q[pos].idx);
                end
                if (!model_q[pos].complete && !dup) begin
                    set_completion(c, pos, 1'b0);
                end
            end
        end
    endtask

    task automatic drain(int limit);
        int cycles;
        cycles = 0;
        while (model_q.size() != 0) begin
            if (cycles >= limit) begin
                report_timeout("the ROB to drain");
            end
            complete_random();
            tick();
            cycles++;
        end
    endtask

    task automatic dispatch_cycles(int n);
        repeat (n) begin
            set_dispatch(DP_NUM);
            tick();
        end
    endtask

//--------------------------------------------------------------------------
// Scenarios
//--------------------------------------------------------------------------
    initial begin : scenarios
        expect_t e;
        int      cycles;
        int      base;
        addr_t   mis_target;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // Empty ROB right after reset
        @(negedge clk_i);
        compare_value("avail_num", DP_NUM, rob_dp.avail_num);
        for (int i = 0; i < DP_NUM; i++) begin
            compare_value("rob_idx", i, rob_dp.rob_idx[i]);
        end
        for (int i = 0; i < RT_NUM; i++) begin
            compare_value("retire valid", 0, rob_rt[i].valid);
        end
        compare_value("br_mis_valid", 0, br_mis_valid);
        tick();

        test_name = "in_order";
        repeat (60) begin
            set_dispatch(int'(rand_bits(2)) % (DP_NUM + 1));
            complete_random();
            tick();
        end
        drain(200);
        compare_value("retired count", disp_cnt, ret_cnt);

        // Younger entries done first, head last
        test_name = "head_blocks";
        dispatch_cycles(2);
        set_completion(0, 1, 1'b0);
        set_completion(1, 2, 1'b0);
        tick();
        set_completion(0, 3, 1'b0);
        tick();
        repeat (3) begin
            @(negedge clk_i);
            compare_value("retire 0 valid", 0, rob_rt[0].valid);
            tick();
        end
        set_completion(0, 0, 1'b0);
        tick();
        drain(8);

        test_name = "full";
        cycles    = 0;
        e         = predict_outputs(1'b0);
        while (e.dp.avail_num != 0) begin
            if (cycles >= ROB_ENTRY_NUM) begin
                report_timeout("the ROB to fill");
            end
            set_dispatch(DP_NUM);
            tick();
            cycles++;
            e = predict_outputs(1'b0);
        end
        @(negedge clk_i);
        compare_value("avail_num", 0, rob_dp.avail_num);
        tick();
        // Retire and refill, pointers wrap
        repeat (40) begin
            complete_random();
            set_dispatch(DP_NUM);
            tick();
        end
        drain(200);

        // Branch at position 1 mispredicts, 2 and 3 must never retire
        test_name = "mispredict";
        dispatch_cycles(2);
        base = ret_cnt;
        set_completion(0, 1, 1'b1);
        mis_target = cdb[0].br_target;
        set_completion(1, 2, 1'b0);
        tick();
        set_completion(0, 3, 1'b0);
        tick();
        set_completion(0, 0, 1'b0);
        tick();
        @(negedge clk_i);
        compare_value("br_mis_valid", 1, br_mis_valid);
        compare_value("br_target", mis_target, br_target);
        compare_value("retire 1 valid", 1, rob_rt[1].valid);
        tick();
        @(negedge clk_i);
        compare_value("avail_num", DP_NUM, rob_dp.avail_num);
        compare_value("rob_idx 0", 0, rob_dp.rob_idx[0]);
        tick();
        compare_value("retired count", base + 2, ret_cnt);
        dispatch_cycles(1);
        drain(20);

        test_name = "exception";
        dispatch_cycles(2);
        set_completion(0, 0, 1'b0);
        set_completion(1, 1, 1'b0);
        tick();
        // Head pair ready, exception suppresses it and drops new dispatch
        exception = 1'b1;
        set_dispatch(DP_NUM);
        base = ret_cnt;
        @(negedge clk_i);
        compare_value("retire 0 valid", 0, rob_rt[0].valid);
        tick();
        @(negedge clk_i);
        compare_value("avail_num", DP_NUM, rob_dp.avail_num);
        compare_value("rob_idx 0", 0, rob_dp.rob_idx[0]);
        repeat (4) tick();
        compare_value("retired count", base, ret_cnt);
        repeat (20) begin
            set_dispatch(int'(rand_bits(2)) % (DP_NUM + 1));
            complete_random();
            tick();
        end
        drain(100);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- rob_top.sv
//--------------------------------------------------------------------------
// ROB top. Retire and mispredict outputs are combinational from state
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  rob_pkg::dp_rob_t                           dp_rob_i,
    output rob_pkg::rob_dp_t                           rob_dp_o,
    input  rob_pkg::cdb_t    [rob_pkg::CDB_NUM-1:0]    cdb_i,
    input  logic                                       exception_i,
    output rob_pkg::rob_rt_t [rob_pkg::RT_NUM-1:0]     rob_rt_o,
    output logic                                       br_mis_valid_o,
    output rob_pkg::addr_t                             br_target_o
);
    import rob_pkg::*;

    rob_idx_t                         head;
    rob_idx_t                         tail;
    logic                             flush;
    logic       [ROB_ENTRY_NUM-1:0]   rt_sel;
    rt_cnt_t                          rt_num;
    rob_entry_t [ROB_ENTRY_NUM-1:0]   entries;

//--------------------------------------------------------------------------
// Pointers and free count
//--------------------------------------------------------------------------
    rob_pointers u_pointers (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .flush_i  (flush),
        .dp_num_i (dp_rob_i.dp_num),
        .rt_num_i (rt_num),
        .head_o   (head),
        .tail_o   (tail),
        .rob_dp_o (rob_dp_o)
    );

//--------------------------------------------------------------------------
// Entry storage
//--------------------------------------------------------------------------
    rob_entry_array u_entry_array (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush),
        .tail_i    (tail),
        .dp_rob_i  (dp_rob_i),
        .cdb_i     (cdb_i),
        .rt_sel_i  (rt_sel),
        .entries_o (entries)
    );

//--------------------------------------------------------------------------
// Retire and flush decision
//--------------------------------------------------------------------------
    rob_retire_select u_retire_select (
        .head_i         (head),
        .entries_i      (entries),
        .exception_i    (exception_i),
        .rt_sel_o       (rt_sel),
        .rt_num_o       (rt_num),
        .rob_rt_o       (rob_rt_o),
        .br_mis_valid_o (br_mis_valid_o),
        .br_target_o    (br_target_o),
        .flush_o        (flush)
    );

endmodule

`default_nettype wire
